// File: tests/issue_input.txt
# D fu rd rs1 rs2 imm op mem itype lui spec t1 t2 | W reg tag data | F fu | B | Z cycles done_mask
# E fu rdat1 rdat2 | N fu state cycles (0 EMPTY 1 WAIT 2 RDY 3 EX) | imm and data in hex
# register contents
W 1 0 00000011
W 2 0 00000022
W 3 0 0000abcd
# single issue, immediate and LUI operands
D 0 4 1 2 00000000 0 0 0 0 0 0 0
E 0 00000011 00000022
F 0
D 0 5 3 2 00000100 1 0 1 0 0 0 0
E 0 0000abcd 00000100
F 0
D 0 6 3 1 12345000 0 0 1 1 0 0 0
E 0 00000000 12345000
F 0
# load waits on the ALU tag
D 1 7 9 2 00000008 0 1 1 0 0 1 0
N 1 1 4
W 9 1 deadbeef
E 1 deadbeef 00000008
F 1
# oldest first when two rows wake together
D 1 8 1 2 00000000 0 2 0 0 0 3 0
D 2 0 2 3 00000000 1 0 0 0 0 0 3
W 10 3 00000077
E 1 00000011 00000022
E 2 00000022 0000abcd
F 1
F 2
# ALU held in EX while an older load needs its result
D 1 11 12 0 00000000 0 1 0 0 0 1 0
D 0 12 1 2 00000000 2 0 0 0 0 0 0
E 0 00000011 00000022
F 0
N 0 3 3
W 12 1 00000055
E 1 00000055 00000000
F 1
F 0
N 0 0 2
# freeze holds the issue register
D 0 13 3 1 00000000 3 0 0 0 0 0 0
E 0 0000abcd 00000011
Z 4 1
F 0
N 0 0 2
# branch miss drops a speculative waiting row
D 0 14 1 2 00000000 0 0 0 0 1 3 0
N 0 1 3
B
N 0 0 4
W 15 3 00000099
N 0 0 4

// File: issue.f
+incdir+src
src/isa_pkg.sv
src/issue_pkg.sv
src/regfile.sv
src/fust_s.sv
src/issue_select.sv
src/issue.sv
tests/issue_tb.sv

// File: Bender.yml
package:
  name: issue

sources:
  - include_dirs:
      - src
    files:
      - src/isa_pkg.sv
      - src/issue_pkg.sv
      - src/regfile.sv
      - src/fust_s.sv
      - src/issue_select.sv
      - src/issue.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/issue_tb.sv

// File: tests/issue_tb.sv
/* issue stage testbench */

`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_tb
    import isa_pkg::*;
    import issue_pkg::*;
();

    logic                      CLK;
    logic                      nRST;
    dispatch_t                 dispatch;
    wb_t                       wb;
    logic [`NUM_FU-1:0]        fu_done;
    logic                      branch_miss;
    issue_t                    out;
    fust_state_e [`NUM_FU-1:0] fust_state;
    logic [`NUM_FU-1:0]        fust_busy;

    // reference model of registers and the last row sent to each unit
    word_t              model_regs [2**`REG_W];
    fust_row_t          model_row [`NUM_FU];
    logic [`NUM_FU-1:0] model_en;
    int                 fd;

    issue i_issue (
        .CLK         (CLK),
        .nRST        (nRST),
        .dispatch    (dispatch),
        .wb          (wb),
        .fu_done     (fu_done),
        .branch_miss (branch_miss),
        .out         (out),
        .fust_state  (fust_state),
        .fust_busy   (fust_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic abort_run;
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_issue(input issue_t got, input issue_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_state(input fust_state_e got, input fust_state_e exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mask(input logic [`NUM_FU-1:0] got, input logic [`NUM_FU-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic need_fields(input int n, input int want, input string what);
        if (n != want) begin
            report_failure($sformatf("input file has a malformed %s line", what));
        end
    endtask

    task automatic skip_comment;
        int c;
        c = $fgetc(fd);
        while (c != "\n" && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    task automatic check_reset;
        check_issue(out, '0, "issue bundle after reset");
        check_mask(fust_busy, '0, "fust_busy after reset");
        for (int i = 0; i < `NUM_FU; i++) begin
            check_state(fust_state[i], FUST_EMPTY, "row state after reset");
        end
    endtask

    task automatic do_dispatch;
        int        n, fu, rd, rs1, rs2;
        int        op, mem, itype, lui, spec, t1, t2;
        word_t     imm;
        fust_row_t row;
        n = $fscanf(fd, "%d %d %d %d %h %d %d %d %d %d %d %d",
                    fu, rd, rs1, rs2, imm, op, mem, itype, lui, spec, t1, t2);
        need_fields(n, 12, "dispatch");
        row          = '0;
        row.rd       = regbits_t'(rd);
        row.rs1      = regbits_t'(rs1);
        row.rs2      = regbits_t'(rs2);
        row.imm      = imm;
        row.op_type  = 4'(op);
        row.mem_type = scalar_mem_t'(mem);
        row.i_type   = itype[0];
        row.lui      = lui[0];
        row.spec     = spec[0];
        row.t1       = tag_t'(t1);
        row.t2       = tag_t'(t2);
        @(negedge CLK);
        if (fust_busy[fu]) begin
            report_failure($sformatf("unit %0d was still busy when a dispatch was due", fu));
        end
        @(posedge CLK);
        dispatch.en  <= 1'b1;
        dispatch.fu  <= fu_idx_t'(fu);
        dispatch.row <= row;
        @(posedge CLK);
        dispatch.en  <= 1'b0;
        model_row[fu] = row;
    endtask

    task automatic do_writeback;
        int    n, sel, tag;
        word_t data;
        n = $fscanf(fd, "%d %d %h", sel, tag, data);
        need_fields(n, 3, "writeback");
        @(posedge CLK);
        wb.reg_en  <= 1'b1;
        wb.reg_sel <= regbits_t'(sel);
        wb.wdat    <= data;
        wb.tag     <= tag_t'(tag);
        @(posedge CLK);
        wb.reg_en  <= 1'b0;
        wb.tag     <= '0;
        // register 0 stays zero
        if (sel != 0) begin
            model_regs[sel] = data;
        end
    endtask

    task automatic pulse_done;
        int n, u;
        n = $fscanf(fd, "%d", u);
        need_fields(n, 1, "done");
        @(posedge CLK);
        fu_done[u] <= 1'b1;
        @(posedge CLK);
        fu_done    <= '0;
        model_en[u] = 1'b0;
    endtask

    task automatic pulse_branch_miss;
        @(posedge CLK);
        branch_miss <= 1'b1;
        @(posedge CLK);
        branch_miss <= 1'b0;
    endtask

    // freeze for some cycles with optional done pulses in the first one
    task automatic hold_freeze;
        int     n, cycles, mask, k;
        issue_t held;
        n = $fscanf(fd, "%d %d", cycles, mask);
        need_fields(n, 2, "freeze");
        @(negedge CLK);
        held = out;
        @(posedge CLK);
        dispatch.freeze <= 1'b1;
        fu_done         <= mask[`NUM_FU-1:0];
        for (k = 0; k < cycles; k++) begin
            @(posedge CLK);
            fu_done <= '0;
            @(negedge CLK);
            check_issue(out, held, "issue bundle under freeze");
        end
        @(posedge CLK);
        dispatch.freeze <= 1'b0;
    endtask

    task automatic expect_issue;
        int                 n, u, waited;
        word_t              r1, r2;
        fust_row_t          row;
        issue_t             exp;
        logic [`NUM_FU-1:0] bit_u;
        n = $fscanf(fd, "%d %h %h", u, r1, r2);
        need_fields(n, 3, "expected issue");
        waited = 0;
        @(negedge CLK);
        while (!out.fu_en[u] && waited < 50) begin
            @(negedge CLK);
            waited++;
        end
        if (!out.fu_en[u]) begin
            report_failure($sformatf("timeout, unit %0d did not issue within 50 cycles", u));
        end
        row      = model_row[u];
        bit_u    = '0;
        bit_u[u] = 1'b1;
        exp             = '0;
        exp.fu_en       = model_en | bit_u;
        exp.rd          = row.rd;
        exp.rdat1       = row.lui ? '0 : model_regs[row.rs1];
        exp.rdat2       = row.i_type ? row.imm : model_regs[row.rs2];
        exp.imm         = row.imm;
        exp.alu_op      = aluop_t'(row.op_type);
        exp.mem_type    = row.mem_type;
        exp.branch_type = branch_t'(row.op_type[2:0]);
        exp.spec        = (u == FU_ALU) && row.spec;
        check_issue(out, exp, "issue bundle");
        check_word(out.rdat1, r1, "rdat1 against input file");
        check_word(out.rdat2, r2, "rdat2 against input file");
        model_en = exp.fu_en;
    endtask

    task automatic expect_idle;
        int                 n, u, st, cycles, k;
        logic [`NUM_FU-1:0] bit_u;
        n = $fscanf(fd, "%d %d %d", u, st, cycles);
        need_fields(n, 3, "expect none");
        for (k = 0; k < cycles; k++) begin
            @(negedge CLK);
            check_mask(out.fu_en, model_en, "fu_en with no issue due");
        end
        check_state(fust_state[u], fust_state_e'(st), "row state");
        // an occupied row keeps its unit busy
        bit_u    = '0;
        bit_u[u] = 1'b1;
        check_mask(fust_busy & bit_u, (fust_state_e'(st) != FUST_EMPTY) ? bit_u : '0,
                   "fust_busy of the row");
    endtask

    initial begin
        logic [7:0] cmd;
        int         n;
        logic       at_end;
        dispatch    <= '0;
        wb          <= '0;
        fu_done     <= '0;
        branch_miss <= 1'b0;
        nRST        <= 1'b0;
        model_regs  = '{default: '0};
        model_row   = '{default: '0};
        model_en    = '0;
        at_end      = 1'b0;
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_reset();
        fd = $fopen("tests/issue_input.txt", "r");
        if (fd == 0) begin
            report_failure("could not open tests/issue_input.txt");
        end
        while (!at_end) begin
            n = $fscanf(fd, " %c", cmd);
            if (n != 1) begin
                at_end = 1'b1;
            end else begin
                case (cmd)
                    "#": skip_comment();
                    "D": do_dispatch();
                    "W": do_writeback();
                    "F": pulse_done();
                    "B": pulse_branch_miss();
                    "Z": hold_freeze();
                    "E": expect_issue();
                    "N": expect_idle();
                    default: report_failure($sformatf("unknown command %c in input file", cmd));
                endcase
            end
        end
        $fclose(fd);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: src/issue.sv
/* scoreboard issue stage */

`timescale 1ns/1ps
`include "issue_macros.svh"

module issue
    import isa_pkg::*;
    import issue_pkg::*;
(
    input  logic                        CLK,
    input  logic                        nRST,
    input  dispatch_t                   dispatch,
    input  wb_t                         wb,
    input  logic [`NUM_FU-1:0]          fu_done,
    input  logic                        branch_miss,
    output issue_t                      out,
    output fust_state_e [`NUM_FU-1:0]   fust_state,
    output logic [`NUM_FU-1:0]          fust_busy
);

    fust_row_t [`NUM_FU-1:0] rows;
    logic [`NUM_FU-1:0]      issue_now;
    fust_row_t               sel_row;
    word_t                   rf_rdat1;
    word_t                   rf_rdat2;
    issue_t                  n_issue;

    regfile u_regfile (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (wb.reg_en),
        .wsel  (wb.reg_sel),
        .wdata (wb.wdat),
        .rsel1 (sel_row.rs1),
        .rsel2 (sel_row.rs2),
        .rdat1 (rf_rdat1),
        .rdat2 (rf_rdat2)
    );

    fust_s u_fust_s (
        .CLK      (CLK),
        .nRST     (nRST),
        .dispatch (dispatch),
        .wb       (wb),
        .rows     (rows)
    );

    issue_select u_issue_select (
        .CLK         (CLK),
        .nRST        (nRST),
        .dispatch    (dispatch),
        .rows        (rows),
        .fu_done     (fu_done),
        .branch_miss (branch_miss),
        .fust_state  (fust_state),
        .fust_busy   (fust_busy),
        .issue_now   (issue_now)
    );

    // issue_now is one-hot, so at most one row is picked here
    always_comb begin
        sel_row = '0;
        for (int i = 0; i < `NUM_FU; i++) begin
            if (issue_now[i]) begin
                sel_row = rows[i];
            end
        end
    end

    always_comb begin
        n_issue       = out;
        n_issue.fu_en = out.fu_en & ~fu_done;
        if (|issue_now) begin
            n_issue.fu_en       = n_issue.fu_en | issue_now;
            n_issue.rd          = sel_row.rd;
            n_issue.rdat1       = sel_row.lui ? '0 : rf_rdat1;
            n_issue.rdat2       = sel_row.i_type ? sel_row.imm : rf_rdat2;
            n_issue.imm         = sel_row.imm;
            n_issue.alu_op      = aluop_t'(sel_row.op_type);
            n_issue.mem_type    = sel_row.mem_type;
            n_issue.branch_type = branch_t'(sel_row.op_type[2:0]);
            // speculation is tracked on ALU results only
            n_issue.spec        = issue_now[FU_ALU] && !branch_miss && sel_row.spec;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out <= '0;
        end else if (!dispatch.freeze) begin
            out <= n_issue;
        end
    end

endmodule

// File: src/issue_select.sv
/* row state machines and oldest-ready select */

`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_select
    import issue_pkg::*;
(
    input  logic                        CLK,
    input  logic                        nRST,
    input  dispatch_t                   dispatch,
    input  fust_row_t [`NUM_FU-1:0]     rows,
    input  logic [`NUM_FU-1:0]          fu_done,
    input  logic                        branch_miss,
    output fust_state_e [`NUM_FU-1:0]   fust_state,
    output logic [`NUM_FU-1:0]          fust_busy,
    output logic [`NUM_FU-1:0]          issue_now
);

    fust_state_e [`NUM_FU-1:0] state_n;
    age_t [`NUM_FU-1:0]        age;
    age_t [`NUM_FU-1:0]        age_n;
    logic [`NUM_FU-1:0]        disp_hit;
    logic [`NUM_FU-1:0]        flush;
    logic [`NUM_FU-1:0]        ready;
    logic [`NUM_FU-1:0]        done_ok;
    logic [`NUM_FU-1:0]        in_ex;
    logic                      war_hold;
    logic                      sel_found;
    age_t                      sel_age;
    fu_idx_t                   sel_idx;

    always_comb begin
        for (int i = 0; i < `NUM_FU; i++) begin
            disp_hit[i] = dispatch.en && (dispatch.fu == fu_idx_t'(i));
            flush[i]    = branch_miss && rows[i].spec;
            // a flushed row must not issue on its way out
            ready[i]    = (fust_state[i] == FUST_RDY) && !flush[i];
            in_ex[i]    = (fust_state[i] == FUST_EX);
        end
    end

    // ALU result stays put while an older load/store still needs its tag
    assign war_hold = (fust_state[FU_LDST] == FUST_WAIT)
                   && (age[FU_LDST] > age[FU_ALU])
                   && (rows[FU_LDST].t1 == TAG_ALU || rows[FU_LDST].t2 == TAG_ALU);

    always_comb begin
        done_ok = fu_done & in_ex;
        if (war_hold) begin
            done_ok[FU_ALU] = 1'b0;
        end
    end

    // strict compare keeps the lowest index on a tie
    always_comb begin
        sel_found = 1'b0;
        sel_age   = '0;
        sel_idx   = '0;
        issue_now = '0;
        for (int i = 0; i < `NUM_FU; i++) begin
            if (ready[i] && (!sel_found || age[i] > sel_age)) begin
                sel_found = 1'b1;
                sel_age   = age[i];
                sel_idx   = fu_idx_t'(i);
            end
        end
        if (sel_found) begin
            issue_now[sel_idx] = 1'b1;
        end
    end

    always_comb begin
        state_n = fust_state;
        for (int i = 0; i < `NUM_FU; i++) begin
            case (fust_state[i])
                FUST_EMPTY: if (disp_hit[i]) state_n[i] = FUST_WAIT;
                FUST_WAIT: begin
                    if (flush[i]) begin
                        state_n[i] = FUST_EMPTY;
                    end else if (rows[i].t1 == '0 && rows[i].t2 == '0) begin
                        state_n[i] = FUST_RDY;
                    end
                end
                FUST_RDY: begin
                    if (flush[i]) begin
                        state_n[i] = FUST_EMPTY;
                    end else if (issue_now[i]) begin
                        state_n[i] = FUST_EX;
                    end
                end
                FUST_EX: begin
                    if (done_ok[i]) begin
                        state_n[i] = disp_hit[i] ? FUST_WAIT : FUST_EMPTY;
                    end
                end
                default: state_n[i] = FUST_EMPTY;
            endcase
        end
    end

    // free now or freed by a done this cycle
    always_comb begin
        for (int i = 0; i < `NUM_FU; i++) begin
            fust_busy[i] = (fust_state[i] != FUST_EMPTY) && !done_ok[i];
        end
    end

    always_comb begin
        age_n = age;
        if (dispatch.en) begin
            for (int i = 0; i < `NUM_FU; i++) begin
                if (disp_hit[i]) begin
                    age_n[i] = '0;
                end else if (fust_state[i] != FUST_EMPTY && age[i] != '1) begin
                    age_n[i] = age[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fust_state <= {`NUM_FU{FUST_EMPTY}};
            age        <= '0;
        end else begin
            fust_state <= state_n;
            age        <= age_n;
        end
    end

    a_issue_onehot: assert property (
        @(posedge CLK) disable iff (!nRST) $onehot0(issue_now)
    ) else $error("more than one row selected");

    a_single_ex_entry: assert property (
        @(posedge CLK) disable iff (!nRST) $onehot0(in_ex & ~$past(in_ex))
    ) else $error("two rows entered EX on one issue");

endmodule

// File: src/fust_s.sv
/* scalar unit status table */

`timescale 1ns/1ps
`include "issue_macros.svh"

module fust_s
    import issue_pkg::*;
(
    input  logic                      CLK,
    input  logic                      nRST,
    input  dispatch_t                 dispatch,
    input  wb_t                       wb,
    output fust_row_t [`NUM_FU-1:0]   rows
);

    fust_row_t [`NUM_FU-1:0] rows_n;

    // drop any tag the writing unit resolves this cycle
    function automatic fust_row_t clear_tags(fust_row_t r, wb_t w);
        fust_row_t c;
        c = r;
        if (w.reg_en && w.tag != '0) begin
            if (c.t1 == w.tag) begin
                c.t1 = '0;
            end
            if (c.t2 == w.tag) begin
                c.t2 = '0;
            end
        end
        return c;
    endfunction

    always_comb begin
        for (int i = 0; i < `NUM_FU; i++) begin
            if (dispatch.en && dispatch.fu == fu_idx_t'(i)) begin
                // new row, a tag met by the same writeback is stored as zero
                rows_n[i] = clear_tags(dispatch.row, wb);
            end else begin
                rows_n[i] = clear_tags(rows[i], wb);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else begin
            rows <= rows_n;
        end
    end

    a_fu_range: assert property (
        @(posedge CLK) disable iff (!nRST)
        dispatch.en |-> (dispatch.fu <= fu_idx_t'(`NUM_FU - 1))
    ) else $error("dispatch to unit %0d out of range", dispatch.fu);

endmodule

// File: src/regfile.sv
/* scalar register file */

`timescale 1ns/1ps
`include "issue_macros.svh"

module regfile
    import isa_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     wen,
    input  regbits_t wsel,
    input  word_t    wdata,
    input  regbits_t rsel1,
    input  regbits_t rsel2,
    output word_t    rdat1,
    output word_t    rdat2
);

    word_t regs [2**`REG_W];
    logic  wr_live;

    // register 0 never takes a write
    assign wr_live = wen && (wsel != '0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '{default: '0};
        end else if (wr_live) begin
            regs[wsel] <= wdata;
        end
    end

    // same-cycle write is forwarded to the readers
    always_comb begin
        rdat1 = (wr_live && wsel == rsel1) ? wdata : regs[rsel1];
        rdat2 = (wr_live && wsel == rsel2) ? wdata : regs[rsel2];
    end

    a_r0_zero: assert property (
        @(posedge CLK) disable iff (!nRST)
        (wen && wsel == '0) |=> (regs[0] == '0)
    ) else $error("register 0 changed after a write");

endmodule

// File: src/issue_pkg.sv
/* scoreboard types */

`include "issue_macros.svh"

package issue_pkg;

    import isa_pkg::*;

    typedef logic [$clog2(`NUM_FU)-1:0] fu_idx_t;
    typedef logic [`TAG_W-1:0]          tag_t;
    typedef logic [`AGE_W-1:0]          age_t;

    // unit rows, tag of a unit is its index plus one
    localparam fu_idx_t FU_ALU  = 2'd0;
    localparam fu_idx_t FU_LDST = 2'd1;
    localparam tag_t    TAG_ALU = 2'd1;

    typedef enum logic [1:0] {
        FUST_EMPTY,
        FUST_WAIT,
        FUST_RDY,
        FUST_EX
    } fust_state_e;

    typedef struct packed {
        regbits_t    rd;
        regbits_t    rs1;
        regbits_t    rs2;
        word_t       imm;
        logic [3:0]  op_type;
        scalar_mem_t mem_type;
        logic        i_type;
        logic        lui;
        logic        spec;
        tag_t        t1;
        tag_t        t2;
    } fust_row_t;

    typedef struct packed {
        logic      en;
        fu_idx_t   fu;
        fust_row_t row;
        logic      freeze;
    } dispatch_t;

    typedef struct packed {
        logic     reg_en;
        regbits_t reg_sel;
        word_t    wdat;
        tag_t     tag;
    } wb_t;

    typedef struct packed {
        logic [`NUM_FU-1:0] fu_en;
        regbits_t           rd;
        word_t              rdat1;
        word_t              rdat2;
        word_t              imm;
        aluop_t             alu_op;
        scalar_mem_t        mem_type;
        branch_t            branch_type;
        logic               spec;
    } issue_t;

endpackage

// File: src/isa_pkg.sv
/* architectural types */

`include "issue_macros.svh"

package isa_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`REG_W-1:0]  regbits_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU
    } aluop_t;

    // scalar memory access kind
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } scalar_mem_t;

    // branch condition, jumps share the encoding
    typedef enum logic [2:0] {
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } branch_t;

endpackage

// File: src/issue_macros.svh
/* issue stage widths and counts */

`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// data word width
`define WORD_W 32

// register index width
`define REG_W 5

// scalar units, one status row each
`define NUM_FU 3

// saturating age counter width
`define AGE_W 2

// producer tag width, zero means operand ready
`define TAG_W 2

`endif
